/* ex_mem_wb.f */
src/core_pkg.sv
src/forward_unit.sv
src/fu_alu.sv
src/fu_br.sv
src/lsu_align.sv
src/data_ram.sv
src/pipe_regs.sv
src/ex_mem_wb.sv
verif/tb_ex_mem_wb.sv

/* verif/tb_ex_mem_wb.sv */
module tb_ex_mem_wb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_pairs   = 2000;
  localparam int mem_bytes = 64;                  // Small window so loads find stored bytes

  logic                      clk;
  logic                      rst_n;
  core_pkg::ex_slot_t        ex_a;
  core_pkg::ex_slot_t        ex_b;
  core_pkg::wb_port_t        wb_a;
  core_pkg::wb_port_t        wb_b;
  logic                      br_fix;
  logic [core_pkg::xlen-1:0] br_pc;

  logic [core_pkg::xlen-1:0] arch [32];           // State after every issued pair
  logic [core_pkg::xlen-1:0] rfile [32];          // Register file, three pairs behind
  logic [7:0]                mem_model [mem_bytes];
  logic                      mem_valid [mem_bytes];
  core_pkg::wb_port_t        exp_q [$];
  core_pkg::wb_port_t        chk_a;
  core_pkg::wb_port_t        chk_b;
  core_pkg::ex_slot_t        nxt_a;
  core_pkg::ex_slot_t        nxt_b;
  logic                      exp_fix;
  logic [core_pkg::xlen-1:0] exp_pc;
  logic [4:0]                ld_rd;
  logic                      ld_pending;
  int                        cycles;

  ex_mem_wb i_dut (
    .clk(clk), .rst_n(rst_n), .ex_a(ex_a), .ex_b(ex_b),
    .wb_a(wb_a), .wb_b(wb_b), .br_fix(br_fix), .br_pc(br_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wb(input string port, input core_pkg::wb_port_t got,
                          input core_pkg::wb_port_t exp);
    if (got.we !== exp.we || (exp.we && (got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
      $display("mismatch at %0t: %s we=%b waddr=%0d wdata=%h, expected we=%b waddr=%0d wdata=%h",
               $time, port, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
      stop_run();
    end
  endtask

  task automatic check_br(input logic fix, input logic [core_pkg::xlen-1:0] pc,
                          input logic e_fix, input logic [core_pkg::xlen-1:0] e_pc);
    if (fix !== e_fix || (e_fix && pc !== e_pc)) begin
      $display("mismatch at %0t: br_fix=%b br_pc=%h, expected br_fix=%b br_pc=%h",
               $time, fix, pc, e_fix, e_pc);
      stop_run();
    end
  endtask

  function automatic logic [31:0] alu_model(input core_pkg::ex_slot_t s, input logic [31:0] r1,
                                            input logic [31:0] r2);
    logic [31:0] a;
    logic [31:0] b;
    a = s.src_sel1[core_pkg::sel_pc] ? s.pc : (s.src_sel1[core_pkg::sel_reg] ? r1 : 32'd0);
    b = s.src_sel2[core_pkg::sel_imm] ? s.imm : (s.src_sel2[core_pkg::sel_reg] ? r2 : 32'd4);
    case (1'b1)
      s.alu_op[core_pkg::alu_add]:  return a + b;
      s.alu_op[core_pkg::alu_sub]:  return a - b;
      s.alu_op[core_pkg::alu_slt]:  return {31'd0, $signed(a) < $signed(b)};
      s.alu_op[core_pkg::alu_sltu]: return {31'd0, a < b};
      s.alu_op[core_pkg::alu_and]:  return a & b;
      s.alu_op[core_pkg::alu_or]:   return a | b;
      s.alu_op[core_pkg::alu_nor]:  return ~(a | b);
      s.alu_op[core_pkg::alu_xor]:  return a ^ b;
      s.alu_op[core_pkg::alu_sll]:  return a << b[4:0];
      s.alu_op[core_pkg::alu_srl]:  return a >> b[4:0];
      s.alu_op[core_pkg::alu_sra]:  return $signed(a) >>> b[4:0];
      s.alu_op[core_pkg::alu_lu12i]: return b;
      default:                      return 32'd0;
    endcase
  endfunction

  // Mispredict flag and the address fetch should go to
  task automatic branch_model(input core_pkg::ex_slot_t s, input logic [31:0] r1,
                              input logic [31:0] r2, output logic mis, output logic [31:0] redir);
    logic tk;
    case (s.br_type)
      core_pkg::br_beq:  tk = r1 == r2;
      core_pkg::br_bne:  tk = r1 != r2;
      core_pkg::br_blt:  tk = $signed(r1) < $signed(r2);
      core_pkg::br_bge:  tk = $signed(r1) >= $signed(r2);
      core_pkg::br_bltu: tk = r1 < r2;
      core_pkg::br_bgeu: tk = r1 >= r2;
      core_pkg::br_none: tk = 1'b0;
      default:           tk = 1'b1;               // b, bl and jirl
    endcase
    mis   = tk != s.br_pd;
    redir = !tk ? s.pc + 32'd4 : (s.br_type == core_pkg::br_jirl ? r1 : s.pc) + s.imm;
  endtask

  // Kind 0 is an idle slot and kind 2 a load or store at a random byte
  function automatic core_pkg::ex_slot_t random_slot(input int kind);
    core_pkg::ex_slot_t s;
    int                 addr;
    int                 w;
    logic               ok;
    s          = '0;
    if (kind == 0) return s;
    s.pc       = $urandom() & 32'hffff_fffc;
    s.raddr1   = $urandom_range(0, 7);            // Few registers give many hazards
    s.raddr2   = $urandom_range(0, 7);
    s.imm      = $urandom();
    s.src_sel1 = 3'b001 << $urandom_range(0, 2);
    s.src_sel2 = 3'b001 << $urandom_range(0, 2);
    s.alu_op   = 12'b1 << $urandom_range(0, 11);
    s.br_type  = $urandom_range(0, 2) == 0 ? $urandom_range(1, 9) : 0;
    s.br_pd    = s.br_type != core_pkg::br_none && $urandom_range(0, 1) == 1;
    s.rf_we    = $urandom_range(0, 3) != 0;
    s.rf_waddr = $urandom_range(0, 7);
    if (kind == 2) begin
      addr       = $urandom_range(0, mem_bytes - 1);
      s.src_sel1 = 3'b001 << core_pkg::sel_zero;  // Address is zero plus imm
      s.src_sel2 = 3'b001 << core_pkg::sel_imm;
      s.alu_op   = 12'b1 << core_pkg::alu_add;
      s.imm      = addr;
      s.br_type  = core_pkg::br_none;
      s.br_pd    = 1'b0;
      case ($urandom_range(0, 4))
        0: s.mem_type = core_pkg::mem_ld_w;
        1: s.mem_type = core_pkg::mem_ld_h;
        2: s.mem_type = core_pkg::mem_ld_hu;
        3: s.mem_type = core_pkg::mem_ld_b;
        default: s.mem_type = core_pkg::mem_ld_bu;
      endcase
      w  = s.mem_type == core_pkg::mem_ld_w ? 4 : (s.mem_type[0] ? 2 : 1);
      ok = 1'b1;
      for (int i = 0; i < w; i++) ok &= mem_valid[addr - addr % w + i];
      s.rf_we = ok && $urandom_range(0, 1) == 1;  // Only loads write back
      if (!s.rf_we) begin
        case ($urandom_range(0, 2))
          0: s.mem_type = core_pkg::mem_st_w;
          1: s.mem_type = core_pkg::mem_st_h;
          default: s.mem_type = core_pkg::mem_st_b;
        endcase
      end
    end
    return s;
  endfunction

  // Byte lanes follow the width and a load returns its extended value
  task automatic access_mem(input core_pkg::mem_type_t t, input int addr,
                            input logic [31:0] data, inout logic [31:0] val);
    int w;
    int base;
    w    = t inside {core_pkg::mem_st_w, core_pkg::mem_ld_w} ? 4 :
           (t inside {core_pkg::mem_st_h, core_pkg::mem_ld_h, core_pkg::mem_ld_hu} ? 2 : 1);
    base = addr - addr % w;
    if (t inside {core_pkg::mem_st_w, core_pkg::mem_st_h, core_pkg::mem_st_b}) begin
      for (int i = 0; i < w; i++) begin
        mem_model[base + i] = data[8*i +: 8];
        mem_valid[base + i] = 1'b1;
      end
    end else begin
      val = '0;
      for (int i = 0; i < w; i++) val[8*i +: 8] = mem_model[base + i];
      if (t == core_pkg::mem_ld_h) val = {{16{val[15]}}, val[15:0]};
      if (t == core_pkg::mem_ld_b) val = {{24{val[7]}}, val[7:0]};
    end
  endtask

  task automatic run_pair(input logic idle);
    logic [31:0]        oa1;
    logic [31:0]        oa2;
    logic [31:0]        ob1;
    logic [31:0]        ob2;
    logic               mis_a;
    logic               mis_b;
    logic [31:0]        red_a;
    logic [31:0]        red_b;
    int                 sel;
    core_pkg::wb_port_t exp_a;
    core_pkg::wb_port_t exp_b;
    sel   = idle ? 3 : $urandom_range(0, 3);
    nxt_a = random_slot(idle ? 0 : (sel == 1 ? 2 : 1));
    nxt_b = random_slot(idle ? 0 : (sel == 2 ? 2 : 1));
    if (ld_pending) begin                         // Load value is not bypassed from MEM
      if (nxt_a.raddr1 == ld_rd) nxt_a.raddr1 = '0;
      if (nxt_a.raddr2 == ld_rd) nxt_a.raddr2 = '0;
      if (nxt_b.raddr1 == ld_rd) nxt_b.raddr1 = '0;
      if (nxt_b.raddr2 == ld_rd) nxt_b.raddr2 = '0;
    end
    nxt_a.rdata1 = rfile[nxt_a.raddr1];
    nxt_a.rdata2 = rfile[nxt_a.raddr2];
    nxt_b.rdata1 = rfile[nxt_b.raddr1];
    nxt_b.rdata2 = rfile[nxt_b.raddr2];
    oa1 = arch[nxt_a.raddr1];
    oa2 = arch[nxt_a.raddr2];
    ob1 = arch[nxt_b.raddr1];
    ob2 = arch[nxt_b.raddr2];
    branch_model(nxt_a, oa1, oa2, mis_a, red_a);
    branch_model(nxt_b, ob1, ob2, mis_b, red_b);
    exp_fix = mis_a | mis_b;
    exp_pc  = mis_a ? red_a : red_b;              // Slot A wins
    exp_a   = '{we: nxt_a.rf_we, waddr: nxt_a.rf_waddr, wdata: alu_model(nxt_a, oa1, oa2)};
    exp_b   = '{we: nxt_b.rf_we & ~mis_a, waddr: nxt_b.rf_waddr,
                wdata: alu_model(nxt_b, ob1, ob2)};
    if (nxt_a.mem_type != core_pkg::mem_none) begin
      access_mem(nxt_a.mem_type, int'(exp_a.wdata), oa2, exp_a.wdata);
    end else if (nxt_b.mem_type != core_pkg::mem_none && !mis_a) begin
      access_mem(nxt_b.mem_type, int'(exp_b.wdata), ob2, exp_b.wdata);
    end
    if (exp_a.we && exp_a.waddr != 0) arch[exp_a.waddr] = exp_a.wdata;
    if (exp_b.we && exp_b.waddr != 0) arch[exp_b.waddr] = exp_b.wdata;
    ld_pending = (exp_a.we && nxt_a.mem_type != core_pkg::mem_none) ||
                 (exp_b.we && nxt_b.mem_type != core_pkg::mem_none);
    ld_rd      = nxt_a.mem_type != core_pkg::mem_none ? nxt_a.rf_waddr : nxt_b.rf_waddr;
    exp_q.push_back(exp_a);
    exp_q.push_back(exp_b);
  endtask

  initial begin
    void'($urandom(3042));
    rst_n      = 1'b0;
    ex_a       = '0;
    ex_b       = '0;
    ld_pending = 1'b0;
    ld_rd      = '0;
    for (int i = 0; i < 32; i++) begin
      rfile[i] = i == 0 ? 32'd0 : $urandom();     // Whatever the register file holds
      arch[i]  = rfile[i];
    end
    for (int i = 0; i < mem_bytes; i++) begin
      mem_model[i] = '0;
      mem_valid[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (rst_n !== 1'b1 && cycles < 16) begin
      cycles++;
      @(negedge clk);
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was not released within 16 cycles");
      stop_run();
    end
    check_br(br_fix, br_pc, 1'b0, '0);            // Idle outputs right after reset
    check_wb("wb_a", wb_a, '0);
    check_wb("wb_b", wb_b, '0);
    for (int p = 0; p < n_pairs + 2; p++) begin
      @(posedge clk);
      run_pair(p >= n_pairs);                     // Two idle pairs drain the pipe
      ex_a <= nxt_a;
      ex_b <= nxt_b;
      @(negedge clk);
      check_br(br_fix, br_pc, exp_fix, exp_pc);
      chk_a = '0;
      chk_b = '0;
      if (exp_q.size() == 6) begin
        chk_a = exp_q.pop_front();
        chk_b = exp_q.pop_front();
      end
      check_wb("wb_a", wb_a, chk_a);
      check_wb("wb_b", wb_b, chk_b);
      if (chk_a.we && chk_a.waddr != 0) rfile[chk_a.waddr] = chk_a.wdata;
      if (chk_b.we && chk_b.waddr != 0) rfile[chk_b.waddr] = chk_b.wdata;
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* src/ex_mem_wb.sv */
module ex_mem_wb (
  input  logic                      clk,
  input  logic                      rst_n,
  input  core_pkg::ex_slot_t        ex_a,
  input  core_pkg::ex_slot_t        ex_b,
  output core_pkg::wb_port_t        wb_a,
  output core_pkg::wb_port_t        wb_b,
  output logic                      br_fix,
  output logic [core_pkg::xlen-1:0] br_pc
);

  logic [core_pkg::xlen-1:0]       opa1;
  logic [core_pkg::xlen-1:0]       opa2;
  logic [core_pkg::xlen-1:0]       opb1;
  logic [core_pkg::xlen-1:0]       opb2;
  logic [core_pkg::xlen-1:0]       alu_a;
  logic [core_pkg::xlen-1:0]       alu_b;
  logic                            kill_b;
  logic                            mem_use_a;
  core_pkg::mem_type_t             st_type;
  logic [core_pkg::xlen-1:0]       mem_addr;
  logic [core_pkg::xlen-1:0]       st_data;
  logic                            st_we;
  logic [3:0]                      byte_we;
  logic [core_pkg::xlen-1:0]       ram_wdata;
  logic [core_pkg::xlen-1:0]       ram_rdata;
  core_pkg::mem_slot_t             ex_mem_a;
  core_pkg::mem_slot_t             ex_mem_b;
  core_pkg::mem_slot_t             mem_a;
  core_pkg::mem_slot_t             mem_b;
  logic                            ld_use_a;
  core_pkg::mem_type_t             ld_type;
  logic [1:0]                      ld_offset;
  logic [core_pkg::xlen-1:0]       ld_data;
  logic [core_pkg::xlen-1:0]       mem_wdata_a;
  logic [core_pkg::xlen-1:0]       mem_wdata_b;

  forward_unit i_fwd (
    .ex_a(ex_a), .ex_b(ex_b), .mem_a(mem_a), .mem_b(mem_b), .wb_a(wb_a), .wb_b(wb_b),
    .opa1(opa1), .opa2(opa2), .opb1(opb1), .opb2(opb2)
  );

  fu_alu i_alu_a (.slot(ex_a), .op1_reg(opa1), .op2_reg(opa2), .result(alu_a));
  fu_alu i_alu_b (.slot(ex_b), .op1_reg(opb1), .op2_reg(opb2), .result(alu_b));

  fu_br i_br (
    .ex_a(ex_a), .ex_b(ex_b), .opa1(opa1), .opa2(opa2), .opb1(opb1), .opb2(opb2),
    .kill_b(kill_b), .br_fix(br_fix), .br_pc(br_pc)
  );

  // At most one memory op per pair, A wins if it has one
  assign mem_use_a = ex_a.mem_type != core_pkg::mem_none;
  assign st_type   = mem_use_a ? ex_a.mem_type : ex_b.mem_type;
  assign mem_addr  = mem_use_a ? alu_a : alu_b;
  assign st_data   = mem_use_a ? opa2 : opb2;
  assign st_we     = mem_use_a | ~kill_b;             // Cancelled B never stores

  // Load in MEM comes from whichever slot carries it
  assign ld_use_a  = core_pkg::is_load(mem_a.mem_type);
  assign ld_type   = ld_use_a ? mem_a.mem_type : mem_b.mem_type;
  assign ld_offset = ld_use_a ? mem_a.alu_result[1:0] : mem_b.alu_result[1:0];

  lsu_align i_lsu (
    .st_type(st_type), .st_addr(mem_addr[1:0]), .st_data(st_data), .st_we(st_we),
    .byte_we(byte_we), .ram_wdata(ram_wdata),
    .ld_type(ld_type), .ld_offset(ld_offset), .ram_rdata(ram_rdata), .ld_data(ld_data)
  );

  data_ram i_ram (
    .clk(clk), .addr(mem_addr[core_pkg::ram_addr_w+1:2]), .byte_we(byte_we),
    .wdata(ram_wdata), .rdata(ram_rdata)
  );

  assign ex_mem_a = '{rf_we: ex_a.rf_we, rf_waddr: ex_a.rf_waddr,
                      alu_result: alu_a, mem_type: ex_a.mem_type};
  assign ex_mem_b = '{rf_we: ex_b.rf_we, rf_waddr: ex_b.rf_waddr,
                      alu_result: alu_b, mem_type: ex_b.mem_type};

  // Write-back select derived from the MEM-stage type
  assign mem_wdata_a = core_pkg::is_load(mem_a.mem_type) ? ld_data : mem_a.alu_result;
  assign mem_wdata_b = core_pkg::is_load(mem_b.mem_type) ? ld_data : mem_b.alu_result;

  pipe_regs i_regs (
    .clk(clk), .rst_n(rst_n), .kill_b(kill_b),
    .ex_mem_a(ex_mem_a), .ex_mem_b(ex_mem_b), .mem_a(mem_a), .mem_b(mem_b),
    .mem_wdata_a(mem_wdata_a), .mem_wdata_b(mem_wdata_b), .wb_a(wb_a), .wb_b(wb_b)
  );

endmodule

/* src/pipe_regs.sv */
module pipe_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      kill_b,
  input  core_pkg::mem_slot_t       ex_mem_a,
  input  core_pkg::mem_slot_t       ex_mem_b,
  output core_pkg::mem_slot_t       mem_a,
  output core_pkg::mem_slot_t       mem_b,
  input  logic [core_pkg::xlen-1:0] mem_wdata_a,
  input  logic [core_pkg::xlen-1:0] mem_wdata_b,
  output core_pkg::wb_port_t        wb_a,
  output core_pkg::wb_port_t        wb_b
);

  core_pkg::mem_slot_t ex_mem_b_k;

  // Killed B keeps its result but loses its side effects
  always_comb begin
    ex_mem_b_k = ex_mem_b;
    if (kill_b) begin
      ex_mem_b_k.rf_we    = 1'b0;
      ex_mem_b_k.mem_type = core_pkg::mem_none;
    end
  end

  // EX to MEM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_a <= '0;                                // Type none, write off
      mem_b <= '0;
    end else begin
      mem_a <= ex_mem_a;
      mem_b <= ex_mem_b_k;
    end
  end

  // MEM to WB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_a <= '0;
      wb_b <= '0;
    end else begin
      wb_a.we    <= mem_a.rf_we;
      wb_a.waddr <= mem_a.rf_waddr;
      wb_a.wdata <= mem_wdata_a;
      wb_b.we    <= mem_b.rf_we;
      wb_b.waddr <= mem_b.rf_waddr;
      wb_b.wdata <= mem_wdata_b;
    end
  end

endmodule

/* src/data_ram.sv */
module data_ram (
  input  logic                            clk,
  input  logic [core_pkg::ram_addr_w-1:0] addr,
  input  logic [3:0]                      byte_we,
  input  logic [core_pkg::xlen-1:0]       wdata,
  output logic [core_pkg::xlen-1:0]       rdata
);

  logic [core_pkg::xlen-1:0] mem [2**core_pkg::ram_addr_w];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (byte_we[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    rdata <= mem[addr];                           // Old data on same-address write
  end

endmodule

/* src/lsu_align.sv */
module lsu_align (
  input  core_pkg::mem_type_t       st_type,
  input  logic [1:0]                st_addr,
  input  logic [core_pkg::xlen-1:0] st_data,
  input  logic                      st_we,
  output logic [3:0]                byte_we,
  output logic [core_pkg::xlen-1:0] ram_wdata,
  input  core_pkg::mem_type_t       ld_type,
  input  logic [1:0]                ld_offset,
  input  logic [core_pkg::xlen-1:0] ram_rdata,
  output logic [core_pkg::xlen-1:0] ld_data
);

  logic [3:0]  st_mask;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        ld_sext;

  // Little-endian lanes; data is replicated so any lane sees it
  always_comb begin
    st_mask   = 4'b0000;
    ram_wdata = st_data;
    case (st_type)
      core_pkg::mem_st_w: begin
        st_mask = 4'b1111;
      end
      core_pkg::mem_st_h: begin
        st_mask   = st_addr[1] ? 4'b1100 : 4'b0011;
        ram_wdata = {2{st_data[15:0]}};
      end
      core_pkg::mem_st_b: begin
        st_mask   = 4'b0001 << st_addr;
        ram_wdata = {4{st_data[7:0]}};
      end
      default: begin
        st_mask = 4'b0000;                        // Loads and idle slots
      end
    endcase
  end

  assign byte_we = st_we ? st_mask : 4'b0000;

  // Misaligned loads just take the lane at the offset
  assign ld_byte = ram_rdata[{ld_offset, 3'b000} +: 8];
  assign ld_half = ld_offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];
  assign ld_sext = ~ld_type[3];                   // Top bit set means zero extend

  always_comb begin
    case (ld_type)
      core_pkg::mem_ld_h, core_pkg::mem_ld_hu: begin
        ld_data = {{16{ld_sext & ld_half[15]}}, ld_half};
      end
      core_pkg::mem_ld_b, core_pkg::mem_ld_bu: begin
        ld_data = {{24{ld_sext & ld_byte[7]}}, ld_byte};
      end
      default: begin
        ld_data = ram_rdata;                      // Word load
      end
    endcase
  end

endmodule

/* src/fu_br.sv */
module fu_br (
  input  core_pkg::ex_slot_t        ex_a,
  input  core_pkg::ex_slot_t        ex_b,
  input  logic [core_pkg::xlen-1:0] opa1,
  input  logic [core_pkg::xlen-1:0] opa2,
  input  logic [core_pkg::xlen-1:0] opb1,
  input  logic [core_pkg::xlen-1:0] opb2,
  output logic                      kill_b,
  output logic                      br_fix,
  output logic [core_pkg::xlen-1:0] br_pc
);

  logic                      taken_a;
  logic                      taken_b;
  logic                      mis_a;
  logic                      mis_b;
  logic [core_pkg::xlen-1:0] redir_a;
  logic [core_pkg::xlen-1:0] redir_b;

  function automatic logic br_taken(
    input core_pkg::br_type_t        t,
    input logic [core_pkg::xlen-1:0] op1,
    input logic [core_pkg::xlen-1:0] op2
  );
    case (t)
      core_pkg::br_beq:  return op1 == op2;
      core_pkg::br_bne:  return op1 != op2;
      core_pkg::br_blt:  return $signed(op1) < $signed(op2);
      core_pkg::br_bge:  return $signed(op1) >= $signed(op2);
      core_pkg::br_bltu: return op1 < op2;
      core_pkg::br_bgeu: return op1 >= op2;
      core_pkg::br_b, core_pkg::br_bl, core_pkg::br_jirl: return 1'b1;
      default:           return 1'b0;
    endcase
  endfunction

  // Not-taken falls through to pc + 4
  function automatic logic [core_pkg::xlen-1:0] redirect(
    input core_pkg::ex_slot_t        s,
    input logic                      taken,
    input logic [core_pkg::xlen-1:0] op1
  );
    if (!taken) begin
      return s.pc + core_pkg::xlen'(4);
    end
    if (s.br_type == core_pkg::br_jirl) begin
      return op1 + s.imm;                         // Register-relative jump
    end
    return s.pc + s.imm;
  endfunction

  assign taken_a = br_taken(ex_a.br_type, opa1, opa2);
  assign taken_b = br_taken(ex_b.br_type, opb1, opb2);
  assign mis_a   = taken_a != ex_a.br_pd;
  assign mis_b   = taken_b != ex_b.br_pd;
  assign redir_a = redirect(ex_a, taken_a, opa1);
  assign redir_b = redirect(ex_b, taken_b, opb1);

  assign kill_b = mis_a;                          // B lies on the wrong path
  assign br_fix = mis_a | mis_b;
  assign br_pc  = mis_a ? redir_a : redir_b;

endmodule

/* src/fu_alu.sv */
module fu_alu (
  input  core_pkg::ex_slot_t        slot,
  input  logic [core_pkg::xlen-1:0] op1_reg,
  input  logic [core_pkg::xlen-1:0] op2_reg,
  output logic [core_pkg::xlen-1:0] result
);

  logic [core_pkg::xlen-1:0] op1;
  logic [core_pkg::xlen-1:0] op2;
  logic [4:0]                shamt;
  core_pkg::alu_op_t         op;

  assign op    = slot.alu_op;
  assign shamt = op2[4:0];                        // Only low five bits shift

  always_comb begin
    case (1'b1)
      slot.src_sel1[core_pkg::sel_reg]:  op1 = op1_reg;
      slot.src_sel1[core_pkg::sel_pc]:   op1 = slot.pc;
      slot.src_sel1[core_pkg::sel_zero]: op1 = '0;
      default:                           op1 = '0;
    endcase
  end

  always_comb begin
    case (1'b1)
      slot.src_sel2[core_pkg::sel_reg]:  op2 = op2_reg;
      slot.src_sel2[core_pkg::sel_imm]:  op2 = slot.imm;
      slot.src_sel2[core_pkg::sel_four]: op2 = core_pkg::xlen'(4);  // Link address offset
      default:                           op2 = '0;
    endcase
  end

  always_comb begin
    case (1'b1)
      op[core_pkg::alu_add]:   result = op1 + op2;
      op[core_pkg::alu_sub]:   result = op1 - op2;
      op[core_pkg::alu_slt]:   result = core_pkg::xlen'($signed(op1) < $signed(op2));
      op[core_pkg::alu_sltu]:  result = core_pkg::xlen'(op1 < op2);
      op[core_pkg::alu_and]:   result = op1 & op2;
      op[core_pkg::alu_or]:    result = op1 | op2;
      op[core_pkg::alu_nor]:   result = ~(op1 | op2);
      op[core_pkg::alu_xor]:   result = op1 ^ op2;
      op[core_pkg::alu_sll]:   result = op1 << shamt;
      op[core_pkg::alu_srl]:   result = op1 >> shamt;
      op[core_pkg::alu_sra]:   result = $unsigned($signed(op1) >>> shamt);
      op[core_pkg::alu_lu12i]: result = op2;      // Immediate comes pre-shifted
      default:                 result = '0;
    endcase
  end

endmodule

/* src/forward_unit.sv */
module forward_unit (
  input  core_pkg::ex_slot_t        ex_a,
  input  core_pkg::ex_slot_t        ex_b,
  input  core_pkg::mem_slot_t       mem_a,
  input  core_pkg::mem_slot_t       mem_b,
  input  core_pkg::wb_port_t        wb_a,
  input  core_pkg::wb_port_t        wb_b,
  output logic [core_pkg::xlen-1:0] opa1,
  output logic [core_pkg::xlen-1:0] opa2,
  output logic [core_pkg::xlen-1:0] opb1,
  output logic [core_pkg::xlen-1:0] opb2
);

  // Newest writer first: MEM B, MEM A, WB B, WB A
  function automatic logic [core_pkg::xlen-1:0] bypass(
    input logic [core_pkg::reg_addr_w-1:0] raddr,
    input logic [core_pkg::xlen-1:0]       rdata,
    input core_pkg::mem_slot_t             m_a,
    input core_pkg::mem_slot_t             m_b,
    input core_pkg::wb_port_t              w_a,
    input core_pkg::wb_port_t              w_b
  );
    if (raddr == '0) begin
      return rdata;                               // r0 stays zero
    end
    if (m_b.rf_we && m_b.rf_waddr == raddr) begin
      return m_b.alu_result;
    end
    if (m_a.rf_we && m_a.rf_waddr == raddr) begin
      return m_a.alu_result;
    end
    if (w_b.we && w_b.waddr == raddr) begin
      return w_b.wdata;
    end
    if (w_a.we && w_a.waddr == raddr) begin
      return w_a.wdata;
    end
    return rdata;
  endfunction

  assign opa1 = bypass(ex_a.raddr1, ex_a.rdata1, mem_a, mem_b, wb_a, wb_b);
  assign opa2 = bypass(ex_a.raddr2, ex_a.rdata2, mem_a, mem_b, wb_a, wb_b);
  assign opb1 = bypass(ex_b.raddr1, ex_b.rdata1, mem_a, mem_b, wb_a, wb_b);
  assign opb2 = bypass(ex_b.raddr2, ex_b.rdata2, mem_a, mem_b, wb_a, wb_b);

endmodule

/* src/core_pkg.sv */
package core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int ram_addr_w = 10;                // 4 KB of words

  // One-hot ALU operation, bit index per function
  typedef logic [11:0] alu_op_t;
  localparam int alu_add   = 0;
  localparam int alu_sub   = 1;
  localparam int alu_slt   = 2;
  localparam int alu_sltu  = 3;
  localparam int alu_and   = 4;
  localparam int alu_or    = 5;
  localparam int alu_nor   = 6;
  localparam int alu_xor   = 7;
  localparam int alu_sll   = 8;
  localparam int alu_srl   = 9;
  localparam int alu_sra   = 10;
  localparam int alu_lu12i = 11;                 // Passes operand 2

  // One-hot operand source, bit index per source
  typedef logic [2:0] src_sel_t;
  localparam int sel_reg  = 0;                   // Both operands
  localparam int sel_pc   = 1;                   // Operand 1 only
  localparam int sel_zero = 2;                   // Operand 1 only
  localparam int sel_imm  = 1;                   // Operand 2 only
  localparam int sel_four = 2;                   // Operand 2 only

  typedef logic [3:0] br_type_t;
  localparam br_type_t br_none = 4'd0;
  localparam br_type_t br_beq  = 4'd1;
  localparam br_type_t br_bne  = 4'd2;
  localparam br_type_t br_blt  = 4'd3;
  localparam br_type_t br_bge  = 4'd4;
  localparam br_type_t br_bltu = 4'd5;
  localparam br_type_t br_bgeu = 4'd6;
  localparam br_type_t br_b    = 4'd7;
  localparam br_type_t br_bl   = 4'd8;
  localparam br_type_t br_jirl = 4'd9;

  // Bit 3 marks an unsigned byte or half load
  typedef logic [3:0] mem_type_t;
  localparam mem_type_t mem_none  = 4'b0000;
  localparam mem_type_t mem_st_w  = 4'b0001;
  localparam mem_type_t mem_ld_w  = 4'b0010;
  localparam mem_type_t mem_ld_h  = 4'b0011;
  localparam mem_type_t mem_ld_b  = 4'b0100;
  localparam mem_type_t mem_st_b  = 4'b0110;
  localparam mem_type_t mem_st_h  = 4'b0111;
  localparam mem_type_t mem_ld_hu = 4'b1011;
  localparam mem_type_t mem_ld_bu = 4'b1100;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       imm;
    src_sel_t              src_sel1;
    src_sel_t              src_sel2;
    alu_op_t               alu_op;
    br_type_t              br_type;
    logic                  br_pd;                // Predicted taken at fetch
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    mem_type_t             mem_type;
  } ex_slot_t;

  typedef struct packed {
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       alu_result;
    mem_type_t             mem_type;
  } mem_slot_t;

  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wb_port_t;

  function automatic logic is_load(input mem_type_t t);
    return t inside {mem_ld_w, mem_ld_h, mem_ld_b, mem_ld_hu, mem_ld_bu};
  endfunction

endpackage
